//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ci_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= TEST OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- ci_accum.sv
`timescale 1ns/1ps

module ci_accum import ci_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             clr_i,
    input  logic             acc_en_i,
    input  logic             cls_en_i,
    input  logic [PIX_W-1:0] med_i,
    input  logic             valid_i,
    input  logic             region_i,
    input  logic [PIX_W-1:0] mean_i,
    input  logic             rem_zero_i,
    output logic [SUM_W-1:0] sum_o,
    output logic             ci_o,
    output logic             ci_valid_o
);

    logic take;

    assign take = valid_i && region_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_o <= '0;
        end else if (clr_i) begin
            sum_o <= '0;
        end else if (acc_en_i && take) begin
            sum_o <= sum_o + SUM_W'(med_i);
        end
    end

    // median above the mean, or equal to an exact mean.
    assign ci_valid_o = cls_en_i && take;
    assign ci_o       = ci_valid_o &&
                        ((med_i > mean_i) || ((med_i == mean_i) && rem_zero_i));

    // only in-region windows of one pass ever reach the sum.
    a_sum_bound: assert property (@(posedge clk) disable iff (rst)
        sum_o <= SUM_W'(REGION_CNT * PIX_MAX));

endmodule

//--- ci_ctrl.sv
`timescale 1ns/1ps

module ci_ctrl import ci_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    input  logic last_win_i,
    input  logic div_done_i,
    output logic cnt_clr_o,
    output logic acc_clr_o,
    output logic acc_en_o,
    output logic cls_en_o,
    output logic div_start_o,
    output logic progress_done_o,
    output logic done_o
);

    ci_state_e state;
    logic [WAIT_W-1:0] wait_cnt;
    logic wait_over;

    assign wait_over = (wait_cnt == '0);

    // a start only counts in the two waiting states.
    assign cnt_clr_o = start_i && (state == S_IDLE || state == S_READY);
    assign acc_clr_o = start_i && (state == S_IDLE);
    assign acc_en_o  = (state == S_ACCUM) || (state == S_DRAIN);
    assign cls_en_o  = (state == S_CLASSIFY) || (state == S_FLUSH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= S_IDLE;
            wait_cnt        <= '0;
            div_start_o     <= 1'b0;
            progress_done_o <= 1'b0;
            done_o          <= 1'b0;
        end else begin
            div_start_o     <= 1'b0;
            progress_done_o <= 1'b0;
            done_o          <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state <= S_ACCUM;
                    end
                end
                S_ACCUM: begin
                    if (last_win_i) begin
                        state    <= S_DRAIN;
                        wait_cnt <= WAIT_W'(MED_LAT - 1);
                    end
                end
                S_DRAIN: begin
                    if (wait_over) begin
                        state       <= S_DIVIDE;
                        div_start_o <= 1'b1;            // sum is final next cycle.
                    end else begin
                        wait_cnt <= wait_cnt - WAIT_W'(1);
                    end
                end
                S_DIVIDE: begin
                    if (div_done_i) begin
                        state           <= S_READY;
                        progress_done_o <= 1'b1;
                    end
                end
                S_READY: begin
                    if (start_i) begin
                        state <= S_CLASSIFY;
                    end
                end
                S_CLASSIFY: begin
                    if (last_win_i) begin
                        state    <= S_FLUSH;
                        wait_cnt <= WAIT_W'(MED_LAT - 1);
                    end
                end
                S_FLUSH: begin
                    if (wait_over) begin
                        state  <= S_IDLE;
                        done_o <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - WAIT_W'(1);
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // divider launch follows the drain wait directly.
    a_div_start: assert property (@(posedge clk) disable iff (rst)
        div_start_o |-> ($past(state) == S_DRAIN) && (state == S_DIVIDE));

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done_o |=> !done_o);

endmodule

//--- ci_mean_div.sv
`timescale 1ns/1ps

module ci_mean_div import ci_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_i,
    input  logic [SUM_W-1:0] sum_i,
    output logic [PIX_W-1:0] mean_o,
    output logic             rem_zero_o,
    output logic             done_o
);

    logic                 busy;
    logic [DIV_CNT_W-1:0] cnt;
    logic [REM_W-1:0]     rem;
    logic [SUM_W-1:0]     dvd;      // remaining dividend bits with the next one at the msb.
    logic [SUM_W-1:0]     quo;
    logic [REM_W:0]       trial;
    logic [REM_W:0]       diff;
    logic                 q_bit;
    logic [REM_W-1:0]     rem_next;
    logic [SUM_W-1:0]     quo_next;

    // first quotient bit is taken on the start cycle itself.
    assign trial    = start_i ? {{REM_W{1'b0}}, sum_i[SUM_W-1]} : {rem, dvd[SUM_W-1]};
    assign q_bit    = (trial >= (REM_W + 1)'(REGION_CNT));
    assign diff     = trial - (REM_W + 1)'(REGION_CNT);
    assign rem_next = q_bit ? diff[REM_W-1:0] : trial[REM_W-1:0];
    assign quo_next = start_i ? {{(SUM_W - 1){1'b0}}, q_bit} : {quo[SUM_W-2:0], q_bit};

    always_ff @(posedge clk) begin
        if (start_i || busy) begin
            rem <= rem_next;
            quo <= quo_next;
            dvd <= start_i ? (sum_i << 1) : (dvd << 1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            cnt        <= '0;
            done_o     <= 1'b0;
            mean_o     <= '0;
            rem_zero_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy <= 1'b1;
                cnt  <= DIV_CNT_W'(SUM_W - 1);     // remaining bits.
            end else if (busy) begin
                cnt <= cnt - DIV_CNT_W'(1);
                if (cnt == DIV_CNT_W'(1)) begin
                    busy       <= 1'b0;
                    done_o     <= 1'b1;
                    mean_o     <= quo_next[PIX_W-1:0];
                    rem_zero_o <= (rem_next == '0);
                end
            end
        end
    end

    // quotient fits a pixel and the remainder is below the divisor.
    a_div_result: assert property (@(posedge clk) disable iff (rst)
        done_o |-> (rem < REM_W'(REGION_CNT)) && (quo[SUM_W-1:PIX_W] == '0));

endmodule

//--- ci_median9.sv
`timescale 1ns/1ps

module ci_median9 import ci_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_i,
    input  logic             region_i,
    input  logic [PIX_W-1:0] s1_i,
    input  logic [PIX_W-1:0] s2_i,
    input  logic [PIX_W-1:0] s3_i,
    input  logic [PIX_W-1:0] s4_i,
    input  logic [PIX_W-1:0] s5_i,
    input  logic [PIX_W-1:0] s6_i,
    input  logic [PIX_W-1:0] s7_i,
    input  logic [PIX_W-1:0] s8_i,
    input  logic [PIX_W-1:0] s9_i,
    output logic [PIX_W-1:0] med_o,
    output logic             valid_o,
    output logic             region_o
);

    logic [PIX_W-1:0] lo_q  [3];
    logic [PIX_W-1:0] mid_q [3];
    logic [PIX_W-1:0] hi_q  [3];
    logic             valid_q;
    logic             region_q;

    function automatic logic [PIX_W-1:0] min2(input logic [PIX_W-1:0] a,
                                              input logic [PIX_W-1:0] b);
        return (a < b) ? a : b;
    endfunction

    function automatic logic [PIX_W-1:0] max2(input logic [PIX_W-1:0] a,
                                              input logic [PIX_W-1:0] b);
        return (a < b) ? b : a;
    endfunction

    function automatic logic [PIX_W-1:0] min3(input logic [PIX_W-1:0] a,
                                              input logic [PIX_W-1:0] b,
                                              input logic [PIX_W-1:0] c);
        return min2(min2(a, b), c);
    endfunction

    function automatic logic [PIX_W-1:0] max3(input logic [PIX_W-1:0] a,
                                              input logic [PIX_W-1:0] b,
                                              input logic [PIX_W-1:0] c);
        return max2(max2(a, b), c);
    endfunction

    function automatic logic [PIX_W-1:0] med3(input logic [PIX_W-1:0] a,
                                              input logic [PIX_W-1:0] b,
                                              input logic [PIX_W-1:0] c);
        return max2(min2(a, b), min2(max2(a, b), c));
    endfunction

    // stage one sorts each row of the window.
    always_ff @(posedge clk) begin
        if (valid_i) begin
            lo_q[0]  <= min3(s1_i, s2_i, s3_i);
            mid_q[0] <= med3(s1_i, s2_i, s3_i);
            hi_q[0]  <= max3(s1_i, s2_i, s3_i);
            lo_q[1]  <= min3(s4_i, s5_i, s6_i);
            mid_q[1] <= med3(s4_i, s5_i, s6_i);
            hi_q[1]  <= max3(s4_i, s5_i, s6_i);
            lo_q[2]  <= min3(s7_i, s8_i, s9_i);
            mid_q[2] <= med3(s7_i, s8_i, s9_i);
            hi_q[2]  <= max3(s7_i, s8_i, s9_i);
        end
    end

    // stage two takes the median of max-of-mins, med-of-meds and min-of-maxes.
    always_ff @(posedge clk) begin
        if (valid_q) begin
            med_o <= med3(max3(lo_q[0], lo_q[1], lo_q[2]),
                          med3(mid_q[0], mid_q[1], mid_q[2]),
                          min3(hi_q[0], hi_q[1], hi_q[2]));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= 1'b0;
            region_q <= 1'b0;
            valid_o  <= 1'b0;
            region_o <= 1'b0;
        end else begin
            valid_q  <= valid_i;
            region_q <= region_i;
            valid_o  <= valid_q;
            region_o <= region_q;
        end
    end

endmodule

//--- ci_pkg.sv
package ci_pkg;

    // frame geometry.
    localparam int COLS   = 11;
    localparam int ROWS   = 11;
    localparam int RADIUS = 4;

    // windows left once the radius-wide border is trimmed on every side.
    localparam int REGION_CNT = (COLS - 2 * RADIUS) * (ROWS - 2 * RADIUS);

    // datapath widths.
    localparam int PIX_W   = 8;
    localparam int PIX_MAX = (1 << PIX_W) - 1;
    localparam int SUM_W   = 15;                  // holds REGION_CNT * PIX_MAX.
    localparam int POS_W   = 4;                   // row and column counters.

    // median network depth in cycles.
    localparam int MED_LAT = 2;

    // derived widths for the divider and the drain/flush waits.
    localparam int REM_W     = $clog2(REGION_CNT);
    localparam int DIV_CNT_W = $clog2(SUM_W);
    localparam int WAIT_W    = $clog2(MED_LAT + 1);

    // controller states.
    typedef enum logic [2:0] {
        S_IDLE,       // waiting for the first start.
        S_ACCUM,      // first pass, summing medians.
        S_DRAIN,      // last medians still in the pipeline.
        S_DIVIDE,     // mean being computed.
        S_READY,      // mean held, waiting for the second start.
        S_CLASSIFY,   // second pass, emitting ci bits.
        S_FLUSH       // last ci bits still in the pipeline.
    } ci_state_e;

endpackage

//--- ci_pos_counter.sv
`timescale 1ns/1ps

module ci_pos_counter import ci_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic clr_i,
    input  logic pix_valid_i,
    output logic in_region_o,
    output logic last_win_o
);

    logic [POS_W-1:0] col;
    logic [POS_W-1:0] row;
    logic col_last;
    logic row_last;
    logic col_in;
    logic row_in;

    assign col_last = (col == POS_W'(COLS - 1));
    assign row_last = (row == POS_W'(ROWS - 1));

    // inside the border on both axes.
    assign col_in = (col >= POS_W'(RADIUS)) && (col <= POS_W'(COLS - 1 - RADIUS));
    assign row_in = (row >= POS_W'(RADIUS)) && (row <= POS_W'(ROWS - 1 - RADIUS));

    assign in_region_o = pix_valid_i && col_in && row_in;
    assign last_win_o  = pix_valid_i && col_last && row_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
            row <= '0;
        end else if (clr_i) begin
            col <= '0;                      // new pass restarts at the top left.
            row <= '0;
        end else if (pix_valid_i) begin
            if (col_last) begin
                col <= '0;
                if (row_last) begin
                    row <= '0;
                end else begin
                    row <= row + POS_W'(1);
                end
            end else begin
                col <= col + POS_W'(1);
            end
        end
    end

    // position stays inside the frame across every pass and clear.
    a_pos_range: assert property (@(posedge clk) disable iff (rst)
        (col < POS_W'(COLS)) && (row < POS_W'(ROWS)));

endmodule

//--- ci_top.sv
`timescale 1ns/1ps

module ci_top import ci_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_i,
    input  logic             pix_valid_i,
    input  logic [PIX_W-1:0] s1_i,
    input  logic [PIX_W-1:0] s2_i,
    input  logic [PIX_W-1:0] s3_i,
    input  logic [PIX_W-1:0] s4_i,
    input  logic [PIX_W-1:0] s5_i,
    input  logic [PIX_W-1:0] s6_i,
    input  logic [PIX_W-1:0] s7_i,
    input  logic [PIX_W-1:0] s8_i,
    input  logic [PIX_W-1:0] s9_i,
    output logic             ci_o,
    output logic             ci_valid_o,
    output logic [PIX_W-1:0] mean_o,
    output logic             progress_done_o,
    output logic             done_o
);

    logic             cnt_clr;
    logic             acc_clr;
    logic             acc_en;
    logic             cls_en;
    logic             div_start;
    logic             div_done;
    logic             in_region;
    logic             last_win;
    logic [PIX_W-1:0] med;
    logic             med_valid;
    logic             med_region;    // in_region delayed beside the median.
    logic [SUM_W-1:0] sum;
    logic             rem_zero;

    ci_ctrl ctrl0 (
        .clk(clk), .rst(rst), .start_i(start_i), .last_win_i(last_win),
        .div_done_i(div_done), .cnt_clr_o(cnt_clr), .acc_clr_o(acc_clr),
        .acc_en_o(acc_en), .cls_en_o(cls_en), .div_start_o(div_start),
        .progress_done_o(progress_done_o), .done_o(done_o)
    );

    ci_pos_counter pos0 (
        .clk(clk), .rst(rst), .clr_i(cnt_clr), .pix_valid_i(pix_valid_i),
        .in_region_o(in_region), .last_win_o(last_win)
    );

    ci_median9 med0 (
        .clk(clk), .rst(rst), .valid_i(pix_valid_i), .region_i(in_region),
        .s1_i(s1_i), .s2_i(s2_i), .s3_i(s3_i), .s4_i(s4_i), .s5_i(s5_i),
        .s6_i(s6_i), .s7_i(s7_i), .s8_i(s8_i), .s9_i(s9_i),
        .med_o(med), .valid_o(med_valid), .region_o(med_region)
    );

    ci_accum acc0 (
        .clk(clk), .rst(rst), .clr_i(acc_clr), .acc_en_i(acc_en), .cls_en_i(cls_en),
        .med_i(med), .valid_i(med_valid), .region_i(med_region), .mean_i(mean_o),
        .rem_zero_i(rem_zero), .sum_o(sum), .ci_o(ci_o), .ci_valid_o(ci_valid_o)
    );

    ci_mean_div div0 (
        .clk(clk), .rst(rst), .start_i(div_start), .sum_i(sum),
        .mean_o(mean_o), .rem_zero_o(rem_zero), .done_o(div_done)
    );

endmodule

//--- flist.f
ci_pkg.sv
ci_ctrl.sv
ci_pos_counter.sv
ci_median9.sv
ci_accum.sv
ci_mean_div.sv
ci_top.sv
tb_ci_top.sv

//--- tb_ci_top.sv
`timescale 1ns/1ps

module tb_ci_top import ci_pkg::*; ();

    localparam int CLK_NS     = 8;
    localparam int NWIN       = COLS * ROWS;
    localparam int MAX_GAP    = 3;
    localparam int N_FRAMES   = 8;
    localparam int WAIT_LIMIT = 64;
    localparam int WDOG_CYC   = 2 * N_FRAMES * (2 * NWIN * (MAX_GAP + 1) + 40) + 100;
    localparam int PH_IDLE     = 0;
    localparam int PH_ACCUM    = 1;
    localparam int PH_CLASSIFY = 2;
    localparam int K_RAND   = 0;
    localparam int K_NARROW = 1;
    localparam int K_FLAT   = 2;
    localparam int K_BRIGHT = 3;

    logic             clk = 1'b0;
    logic             rst;
    logic             start_i;
    logic             pix_valid_i;
    logic [PIX_W-1:0] s [9];
    logic             ci_o;
    logic             ci_valid_o;
    logic [PIX_W-1:0] mean_o;
    logic             progress_done_o;
    logic             done_o;

    logic [PIX_W-1:0] win [NWIN][9];
    logic             exp_bits [REGION_CNT];
    logic [PIX_W-1:0] exp_mean;
    logic             exp_now;
    int               phase = PH_IDLE;
    int               ci_cnt;
    int               prog_cnt;
    logic             done_q = 1'b0;
    logic             rst_q = 1'b0;
    int               assert_errs = 0;
    int               wait_fails = 0;

    always #(CLK_NS / 2) clk = ~clk;

    ci_top dut0 (
        .clk(clk), .rst(rst), .start_i(start_i), .pix_valid_i(pix_valid_i),
        .s1_i(s[0]), .s2_i(s[1]), .s3_i(s[2]), .s4_i(s[3]), .s5_i(s[4]),
        .s6_i(s[5]), .s7_i(s[6]), .s8_i(s[7]), .s9_i(s[8]),
        .ci_o(ci_o), .ci_valid_o(ci_valid_o), .mean_o(mean_o),
        .progress_done_o(progress_done_o), .done_o(done_o)
    );

    assign exp_now = (ci_cnt < REGION_CNT) ? exp_bits[ci_cnt] : 1'b0;

    // pulse bookkeeping per pass and per frame.
    always @(posedge clk) begin
        rst_q  <= rst;
        done_q <= done_o;
        if (rst) begin
            ci_cnt   <= 0;
            prog_cnt <= 0;
        end else begin
            if (start_i) begin
                ci_cnt <= 0;
            end else if (ci_valid_o) begin
                ci_cnt <= ci_cnt + 1;
            end
            if (start_i && phase == PH_ACCUM) begin
                prog_cnt <= 0;                      // new frame.
            end else if (progress_done_o) begin
                prog_cnt <= prog_cnt + 1;
            end
        end
    end

    a_ci_value: assert property (@(posedge clk) disable iff (rst)
        ci_valid_o |-> (ci_o == exp_now))
        else begin
            $display("Mismatch at %0t: ci_o expected %0b got %0b",
                     $time, $sampled(exp_now), $sampled(ci_o));
            assert_errs++;
        end

    a_ci_window: assert property (@(posedge clk) disable iff (rst)
        ci_valid_o |-> (phase == PH_CLASSIFY) && (ci_cnt < REGION_CNT))
        else begin
            $display("ci_valid_o pulsed outside the classify pass at %0t", $time);
            assert_errs++;
        end

    a_ci_count: assert property (@(posedge clk) disable iff (rst)
        done_o |-> (ci_cnt == REGION_CNT))
        else begin
            $display("Mismatch at %0t: ci_valid_o pulse count expected %0d got %0d",
                     $time, REGION_CNT, $sampled(ci_cnt));
            assert_errs++;
        end

    a_mean: assert property (@(posedge clk) disable iff (rst)
        progress_done_o |-> (mean_o == exp_mean))
        else begin
            $display("Mismatch at %0t: mean_o expected %0d got %0d",
                     $time, $sampled(exp_mean), $sampled(mean_o));
            assert_errs++;
        end

    a_progress: assert property (@(posedge clk) disable iff (rst)
        progress_done_o |-> (phase == PH_ACCUM) && (prog_cnt == 0))
        else begin
            $display("progress_done_o pulsed outside the gap between passes at %0t", $time);
            assert_errs++;
        end

    a_done: assert property (@(posedge clk) disable iff (rst)
        done_o |-> (phase == PH_CLASSIFY) && !done_q && (prog_cnt == 1))
        else begin
            $display("done_o at %0t was not a single pulse ending a full frame", $time);
            assert_errs++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        rst_q |-> !ci_valid_o && !progress_done_o && !done_o && (mean_o == '0))
        else begin
            $display("outputs not cleared after reset at %0t", $time);
            assert_errs++;
        end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_start(input int next_phase);
        start_i = 1'b1;
        phase   = next_phase;
        tick();
        start_i = 1'b0;
    endtask

    task automatic wait_pulse(input bit want_done, input string name);
        int n;
        n = 0;
        while (!(want_done ? done_o : progress_done_o) && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!(want_done ? done_o : progress_done_o)) begin
            $display("timed out at %0t waiting for %s", $time, name);
            wait_fails++;
        end
    endtask

    function automatic int median9(input int v [9]);
        int a [9];
        int t;
        a = v;
        for (int i = 1; i < 9; i++) begin
            for (int j = i; j > 0 && a[j-1] > a[j]; j--) begin
                t      = a[j];
                a[j]   = a[j-1];
                a[j-1] = t;
            end
        end
        return a[4];
    endfunction

    function automatic bit in_region(input int r, input int c);
        return (r >= RADIUS) && (r <= ROWS - 1 - RADIUS) &&
               (c >= RADIUS) && (c <= COLS - 1 - RADIUS);
    endfunction

    task automatic gen_frame(input int kind);
        int cur [9];
        int meds [REGION_CNT];
        int n;
        int sum;
        int base;
        n    = 0;
        sum  = 0;
        base = $urandom_range(0, PIX_MAX);
        for (int w = 0; w < NWIN; w++) begin
            for (int k = 0; k < 9; k++) begin
                case (kind)
                    K_NARROW: cur[k] = 40 + $urandom_range(0, 3);  // ties with the mean.
                    K_FLAT:   cur[k] = base;
                    K_BRIGHT: cur[k] = (w == (ROWS / 2) * COLS + COLS / 2) ? 200 : 10;
                    default:  cur[k] = $urandom_range(0, PIX_MAX);
                endcase
                win[w][k] = PIX_W'(cur[k]);
            end
            if (in_region(w / COLS, w % COLS)) begin
                meds[n] = median9(cur);
                sum     = sum + meds[n];
                n++;
            end
        end
        exp_mean = PIX_W'(sum / REGION_CNT);
        for (int i = 0; i < REGION_CNT; i++) begin
            exp_bits[i] = (meds[i] * REGION_CNT >= sum);
        end
    endtask

    task automatic send_pass(input int abort_at);
        int gap;
        for (int w = 0; w < NWIN; w++) begin
            gap = $urandom_range(0, MAX_GAP);
            repeat (gap) tick();
            if (w == abort_at) begin
                rst = 1'b1;                         // pass abandoned halfway.
                repeat (2) tick();
                rst = 1'b0;
                return;
            end
            pix_valid_i = 1'b1;
            for (int k = 0; k < 9; k++) begin
                s[k] = win[w][k];
            end
            tick();
            pix_valid_i = 1'b0;
        end
    endtask

    task automatic run_frame(input int kind, input int abort_at);
        gen_frame(kind);
        pulse_start(PH_ACCUM);
        send_pass(-1);
        wait_pulse(1'b0, "progress_done_o");
        tick();
        pulse_start(PH_CLASSIFY);
        send_pass(abort_at);
        if (abort_at < 0) begin
            wait_pulse(1'b1, "done_o");
            tick();
        end
        phase = PH_IDLE;
        repeat ($urandom_range(1, 4)) tick();
    endtask

    initial begin
        void'($urandom(47));
        rst         = 1'b1;
        start_i     = 1'b0;
        pix_valid_i = 1'b0;
        for (int k = 0; k < 9; k++) begin
            s[k] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();
        run_frame(K_RAND, -1);
        run_frame(K_NARROW, -1);
        run_frame(K_RAND, -1);
        run_frame(K_FLAT, -1);
        run_frame(K_BRIGHT, -1);
        run_frame(K_RAND, NWIN / 2);
        run_frame(K_NARROW, -1);
        run_frame(K_RAND, -1);
        repeat (4) tick();
        $display("errors: %0d assertion, %0d timeout", assert_errs, wait_fails);
        if (assert_errs == 0 && wait_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WDOG_CYC * CLK_NS);
        $display("watchdog expired before all frames finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule
